//--- include/idu_defs.svh
// decode stage sizing macros for widths and issue buffer depth

`ifndef IDU_DEFS_SVH
`define IDU_DEFS_SVH

// data path width of the RV64I core
`define IDU_XLEN 64

// all instructions handled here are 32 bits wide
`define IDU_ILEN 32

// issue buffer entries, which is also the number of credits the fetch
// side holds after reset
// other powers of two work as well
`define IDU_BUF_DEPTH 4

`endif

//--- rtl/idu_pkg.sv
// decode stage types: opcode and control encodings and the packets passed between stages
`default_nettype none
`include "idu_defs.svh"

package idu_pkg;

  typedef enum logic [6:0] {
    LUI       = 7'b0110111,
    AUIPC     = 7'b0010111,
    JAL       = 7'b1101111,
    JALR      = 7'b1100111,
    BRANCH    = 7'b1100011,
    LOAD      = 7'b0000011,
    STORE     = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_IMM_32 = 7'b0011011,
    OP_32     = 7'b0111011,
    SYSTEM    = 7'b1110011
  } opcode_e;

  // codes as the execute stage ALU expects them
  typedef enum logic [3:0] {
    ALU_ADD      = 4'b0000,
    ALU_COPY_IMM = 4'b0011,
    ALU_SUB      = 4'b1000,
    ALU_ADDW     = 4'b1001,
    ALU_EBREAK   = 4'b1110,
    ALU_NONE     = 4'b1111
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE = 3'b000,
    BR_JAL  = 3'b001,
    BR_JALR = 3'b010,
    BR_BNE  = 3'b101
  } branch_e;

  typedef enum logic [2:0] {
    MEM_SB   = 3'b000,
    MEM_UB   = 3'b001,
    MEM_SH   = 3'b010,
    MEM_UH   = 3'b011,
    MEM_SW   = 3'b100,
    MEM_UW   = 3'b101,
    MEM_SD   = 3'b110,
    MEM_NONE = 3'b111
  } mem_op_e;

  typedef enum logic [2:0] {
    IMM_I    = 3'b000,
    IMM_U    = 3'b001,
    IMM_S    = 3'b010,
    IMM_B    = 3'b011,
    IMM_J    = 3'b100,
    IMM_NONE = 3'b111
  } imm_fmt_e;

  typedef struct packed {
    logic [`IDU_XLEN-1:0] pc;
    logic [`IDU_ILEN-1:0] inst;
  } inst_pkt_t;

  typedef struct packed {
    logic     reg_wr;
    logic     alu_a_pc;   // 1 selects pc instead of rs1
    logic [1:0] alu_b_src; // 00 rs2, 01 imm, 10 constant 4
    alu_op_e  alu_op;
    logic     mem_to_reg;
    logic     mem_wr;
    mem_op_e  mem_op;
    branch_e  branch;
    imm_fmt_e imm_fmt;
    logic     illegal;
  } ctrl_t;

  typedef struct packed {
    logic [`IDU_XLEN-1:0] pc;
    logic [4:0]           rs1;
    logic [4:0]           rs2;
    logic [4:0]           rd;
    logic [`IDU_XLEN-1:0] imm;
    ctrl_t                ctrl;
  } dec_pkt_t;

endpackage

`default_nettype wire

//--- rtl/idu_imm_gen.sv
// immediate generator, builds the sign-extended immediate for the instruction format
`timescale 1ns/10ps
`default_nettype none
`include "idu_defs.svh"

module idu_imm_gen
  import idu_pkg::*;
(
  input  wire  [`IDU_ILEN-1:0] i_inst,
  output logic [`IDU_XLEN-1:0] o_imm
);

  opcode_e              opcode;
  logic [`IDU_XLEN-1:0] imm_i;
  logic [`IDU_XLEN-1:0] imm_u;
  logic [`IDU_XLEN-1:0] imm_s;
  logic [`IDU_XLEN-1:0] imm_b;
  logic [`IDU_XLEN-1:0] imm_j;

  assign opcode = opcode_e'(i_inst[6:0]);

  // every format takes its sign from bit 31
  assign imm_i = {{(`IDU_XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{(`IDU_XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_s = {{(`IDU_XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(`IDU_XLEN-12){i_inst[31]}}, i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};
  assign imm_j = {{(`IDU_XLEN-20){i_inst[31]}}, i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};

  always_comb begin
    case (opcode)
      OP_IMM, OP_IMM_32, LOAD, JALR, SYSTEM: o_imm = imm_i;
      LUI, AUIPC:                            o_imm = imm_u;
      STORE:                                 o_imm = imm_s;
      BRANCH:                                o_imm = imm_b;
      JAL:                                   o_imm = imm_j;
      default:                               o_imm = '0; // OP_32 has no immediate
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/idu_ctrl_dec.sv
// control decoder, turns an instruction into register indices and execute controls
`timescale 1ns/10ps
`default_nettype none
`include "idu_defs.svh"

module idu_ctrl_dec
  import idu_pkg::*;
(
  input  wire                  i_clk,
  input  wire                  i_rst_n,
  input  wire  [`IDU_ILEN-1:0] i_inst,
  output logic [4:0]           o_rs1,
  output logic [4:0]           o_rs2,
  output logic [4:0]           o_rd,
  output ctrl_t                o_ctrl
);

  opcode_e     opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic        inst_lui;
  logic        inst_auipc;
  logic        inst_jal;
  logic        inst_jalr;
  logic        inst_bne;
  logic        inst_lw;
  logic        inst_sw;
  logic        inst_addi;
  logic        inst_ebreak;
  logic        inst_sd;
  logic        inst_addiw;
  logic        inst_addw;
  logic        type_r;
  logic        type_i;
  logic        type_u;
  logic        type_s;
  logic        type_b;
  logic        type_j;
  logic [11:0] inst_match;

  assign opcode = opcode_e'(i_inst[6:0]);
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  // register fields are passed on whatever the format
  assign o_rs1 = i_inst[19:15];
  assign o_rs2 = i_inst[24:20];
  assign o_rd  = i_inst[11:7];

  assign inst_lui    = (opcode == LUI);
  assign inst_auipc  = (opcode == AUIPC);
  assign inst_jal    = (opcode == JAL);
  assign inst_jalr   = (opcode == JALR)      && (funct3 == 3'b000);
  assign inst_bne    = (opcode == BRANCH)    && (funct3 == 3'b001);
  assign inst_lw     = (opcode == LOAD)      && (funct3 == 3'b010);
  assign inst_sw     = (opcode == STORE)     && (funct3 == 3'b010);
  assign inst_addi   = (opcode == OP_IMM)    && (funct3 == 3'b000);
  assign inst_ebreak = (opcode == SYSTEM)    && (funct3 == 3'b000);
  assign inst_sd     = (opcode == STORE)     && (funct3 == 3'b011);
  assign inst_addiw  = (opcode == OP_IMM_32) && (funct3 == 3'b000);
  assign inst_addw   = (opcode == OP_32)     && (funct3 == 3'b000) && (funct7 == 7'b0000000);

  assign inst_match = {inst_lui, inst_auipc, inst_jal, inst_jalr, inst_bne, inst_lw,
                       inst_sw, inst_addi, inst_ebreak, inst_sd, inst_addiw, inst_addw};

  assign type_r = inst_addw;
  assign type_i = inst_lw | inst_addi | inst_addiw | inst_ebreak | inst_jalr;
  assign type_u = inst_lui | inst_auipc;
  assign type_s = inst_sw | inst_sd;
  assign type_b = inst_bne;
  assign type_j = inst_jal;

  // an unmatched encoding falls through to the default of every field
  always_comb begin
    o_ctrl.reg_wr     = type_r | type_i | type_u | type_j;
    o_ctrl.alu_a_pc   = inst_jal | inst_jalr | inst_auipc;
    o_ctrl.alu_b_src  = {inst_jal | inst_jalr, (type_i | type_u | type_s) & ~inst_jalr};
    o_ctrl.mem_to_reg = inst_lw;
    o_ctrl.mem_wr     = type_s;
    o_ctrl.illegal    = ~|inst_match;

    if (inst_lui) o_ctrl.alu_op = ALU_COPY_IMM;
    else if (inst_auipc | inst_jal | inst_jalr | inst_lw | inst_sw | inst_addi | inst_sd)
      o_ctrl.alu_op = ALU_ADD;
    else if (inst_addiw | inst_addw) o_ctrl.alu_op = ALU_ADDW;
    else if (inst_bne) o_ctrl.alu_op = ALU_SUB; // bne compares through the subtractor
    else if (inst_ebreak) o_ctrl.alu_op = ALU_EBREAK;
    else o_ctrl.alu_op = ALU_NONE;

    if (inst_lw | inst_sw) o_ctrl.mem_op = MEM_SW;
    else if (inst_sd) o_ctrl.mem_op = MEM_SD;
    else o_ctrl.mem_op = MEM_NONE;

    if (inst_jal) o_ctrl.branch = BR_JAL;
    else if (inst_jalr) o_ctrl.branch = BR_JALR;
    else if (inst_bne) o_ctrl.branch = BR_BNE;
    else o_ctrl.branch = BR_NONE;

    if (type_i) o_ctrl.imm_fmt = IMM_I;
    else if (type_u) o_ctrl.imm_fmt = IMM_U;
    else if (type_s) o_ctrl.imm_fmt = IMM_S;
    else if (type_b) o_ctrl.imm_fmt = IMM_B;
    else if (type_j) o_ctrl.imm_fmt = IMM_J;
    else o_ctrl.imm_fmt = IMM_NONE; // R format and illegal encodings
  end

  // the priority chains above only hold if no two instructions match at once
  a_one_match: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $onehot0(inst_match))
    else $error("idu_ctrl_dec: more than one instruction match");

endmodule

`default_nettype wire

//--- rtl/idu_issue_buf.sv
// issue buffer, queues decoded packets and runs fetch and execute credit flow
`timescale 1ns/10ps
`default_nettype none
`include "idu_defs.svh"

module idu_issue_buf
  import idu_pkg::*;
(
  input  wire                  i_clk,
  input  wire                  i_rst_n,
  input  wire                  i_valid,
  input  wire  [`IDU_XLEN-1:0] i_pc,
  input  wire  [4:0]           i_rs1,
  input  wire  [4:0]           i_rs2,
  input  wire  [4:0]           i_rd,
  input  wire  [`IDU_XLEN-1:0] i_imm,
  input  wire  ctrl_t          i_ctrl,
  output logic                 o_inst_credit,
  input  wire                  i_ex_credit,
  output logic                 o_dec_valid,
  output dec_pkt_t             o_dec
);

  localparam int unsigned DEPTH  = `IDU_BUF_DEPTH;
  localparam int unsigned AW     = $clog2(DEPTH);
  localparam int unsigned CRED_W = 16;

  dec_pkt_t          mem [DEPTH];
  dec_pkt_t          wr_pkt;
  logic [AW-1:0]     wr_ptr;
  logic [AW-1:0]     rd_ptr;
  logic [AW:0]       count;
  logic [CRED_W-1:0] ex_cnt; // execute credits not yet used
  logic              pop;

  assign wr_pkt = '{pc: i_pc, rs1: i_rs1, rs2: i_rs2, rd: i_rd, imm: i_imm, ctrl: i_ctrl};

  // head goes out as soon as there is something to send and a slot downstream
  assign pop         = (count != '0) && (ex_cnt != '0);
  assign o_dec_valid = pop;
  assign o_dec       = mem[rd_ptr];

  always_ff @(posedge i_clk) begin
    if (i_valid) mem[wr_ptr] <= wr_pkt;
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      ex_cnt        <= '0;
      o_inst_credit <= 1'b0;
    end else begin
      if (i_valid) wr_ptr <= wr_ptr + AW'(1);
      if (pop) rd_ptr <= rd_ptr + AW'(1);
      case ({i_valid, pop})
        2'b10:   count <= count + (AW+1)'(1);
        2'b01:   count <= count - (AW+1)'(1);
        default: count <= count;
      endcase
      case ({i_ex_credit, pop})
        2'b10:   ex_cnt <= ex_cnt + CRED_W'(1);
        2'b01:   ex_cnt <= ex_cnt - CRED_W'(1);
        default: ex_cnt <= ex_cnt;
      endcase
      o_inst_credit <= pop; // the freed entry goes back to fetch one cycle later
    end
  end

  // fetch writing into a full buffer means it used more credits than it was given
  a_no_overrun: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_valid |-> (count != (AW+1)'(DEPTH)))
    else $error("idu_issue_buf: write into full buffer");

  a_credit_ovf: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_ex_credit && !pop) |-> (ex_cnt != '1))
    else $error("idu_issue_buf: execute credit counter overflow");

  // once the last credit is spent, output must stay idle until a new one arrives
  a_send_needs_credit: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_dec_valid && (ex_cnt == CRED_W'(1)) && !i_ex_credit) |=> !o_dec_valid)
    else $error("idu_issue_buf: packet sent without execute credit");

endmodule

`default_nettype wire

//--- rtl/idu_top.sv
// decode stage top, feeds both decoders and queues their results for execute
`timescale 1ns/10ps
`default_nettype none
`include "idu_defs.svh"

module idu_top
  import idu_pkg::*;
(
  input  wire            i_clk,
  input  wire            i_rst_n,
  input  wire            i_inst_valid,
  input  wire inst_pkt_t i_inst,
  output logic           o_inst_credit,
  input  wire            i_ex_credit,
  output logic           o_dec_valid,
  output dec_pkt_t       o_dec
);

  logic [`IDU_XLEN-1:0] imm;
  logic [4:0]           rs1;
  logic [4:0]           rs2;
  logic [4:0]           rd;
  ctrl_t                ctrl;

  idu_imm_gen u_imm_gen (
    .i_inst (i_inst.inst),
    .o_imm  (imm)
  );

  idu_ctrl_dec u_ctrl_dec (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_inst  (i_inst.inst),
    .o_rs1   (rs1),
    .o_rs2   (rs2),
    .o_rd    (rd),
    .o_ctrl  (ctrl)
  );

  // pc bypasses the decoders and joins the results in the buffer
  idu_issue_buf u_issue_buf (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_valid       (i_inst_valid),
    .i_pc          (i_inst.pc),
    .i_rs1         (rs1),
    .i_rs2         (rs2),
    .i_rd          (rd),
    .i_imm         (imm),
    .i_ctrl        (ctrl),
    .o_inst_credit (o_inst_credit),
    .i_ex_credit   (i_ex_credit),
    .o_dec_valid   (o_dec_valid),
    .o_dec         (o_dec)
  );

endmodule

`default_nettype wire

//--- sim/tb_idu.sv
// decode stage testbench, random instruction packets checked against a reference decoder
`timescale 1ns/10ps
`default_nettype none
`include "idu_defs.svh"

module tb_idu
  import idu_pkg::*;
();

  localparam int DEPTH = `IDU_BUF_DEPTH;
  localparam int N_PKT = 400;

  logic        clk;
  logic        rst_n;
  logic        inst_valid;
  inst_pkt_t   inst_pkt;
  logic        inst_credit;
  logic        ex_credit;
  logic        dec_valid;
  dec_pkt_t    dec;
  logic [31:0] lfsr_state = 32'h9744581b;
  dec_pkt_t    exp_q[$];
  logic [11:0] legal_seen = '0;
  int          illegal_sent = 0;
  int          fetch_credits = DEPTH; // credits the fetch side still holds
  int          sent = 0;
  int          received = 0;
  int          ex_granted = 0;
  int          errors = 0;
  int          timeouts = 0;
  string       test_name = "reset_idle";

  idu_top i_dut (
    .i_clk         (clk),
    .i_rst_n       (rst_n),
    .i_inst_valid  (inst_valid),
    .i_inst        (inst_pkt),
    .o_inst_credit (inst_credit),
    .i_ex_credit   (ex_credit),
    .o_dec_valid   (dec_valid),
    .o_dec         (dec)
  );

  always #4 clk = ~clk;

  // right shifting Galois LFSR, one step per bit handed out
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'ha3000000) : (lfsr_state >> 1);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // kinds 0..11 are lui auipc jal jalr bne lw sw addi ebreak sd addiw addw
  function automatic logic [31:0] make_inst(input int kind, input logic [31:0] raw);
    case (kind)
      0:       return {raw[31:7], LUI};
      1:       return {raw[31:7], AUIPC};
      2:       return {raw[31:7], JAL};
      3:       return {raw[31:15], 3'b000, raw[11:7], JALR};
      4:       return {raw[31:15], 3'b001, raw[11:7], BRANCH};
      5:       return {raw[31:15], 3'b010, raw[11:7], LOAD};
      6:       return {raw[31:15], 3'b010, raw[11:7], STORE};
      7:       return {raw[31:15], 3'b000, raw[11:7], OP_IMM};
      8:       return {raw[31:15], 3'b000, raw[11:7], SYSTEM};
      9:       return {raw[31:15], 3'b011, raw[11:7], STORE};
      10:      return {raw[31:15], 3'b000, raw[11:7], OP_IMM_32};
      default: return {7'b0000000, raw[24:15], 3'b000, raw[11:7], OP_32};
    endcase
  endfunction

  function automatic int classify(input logic [31:0] inst);
    logic [2:0] f3;
    f3 = inst[14:12];
    case (inst[6:0])
      LUI:       return 0;
      AUIPC:     return 1;
      JAL:       return 2;
      JALR:      return (f3 == 3'b000) ? 3 : -1;
      BRANCH:    return (f3 == 3'b001) ? 4 : -1;
      LOAD:      return (f3 == 3'b010) ? 5 : -1;
      STORE:     return (f3 == 3'b010) ? 6 : ((f3 == 3'b011) ? 9 : -1);
      OP_IMM:    return (f3 == 3'b000) ? 7 : -1;
      SYSTEM:    return (f3 == 3'b000) ? 8 : -1;
      OP_IMM_32: return (f3 == 3'b000) ? 10 : -1;
      OP_32:     return (f3 == 3'b000 && inst[31:25] == 7'b0) ? 11 : -1;
      default:   return -1;
    endcase
  endfunction

  // f holds reg_wr, alu_a_pc, mem_to_reg and mem_wr from msb down
  function automatic ctrl_t pack_ctrl(input logic [3:0] f, input logic [1:0] b_src,
                                      input alu_op_e op, input mem_op_e mop,
                                      input branch_e br, input imm_fmt_e fmt);
    return '{reg_wr: f[3], alu_a_pc: f[2], alu_b_src: b_src, alu_op: op, mem_to_reg: f[1],
             mem_wr: f[0], mem_op: mop, branch: br, imm_fmt: fmt, illegal: 1'b0};
  endfunction

  function automatic dec_pkt_t ref_decode(input logic [63:0] pc, input logic [31:0] inst);
    dec_pkt_t d;
    d.pc  = pc;
    d.rs1 = inst[19:15];
    d.rs2 = inst[24:20];
    d.rd  = inst[11:7];
    case (inst[6:0])
      OP_IMM, OP_IMM_32, LOAD, JALR, SYSTEM: d.imm = 64'($signed(inst[31:20]));
      LUI, AUIPC: d.imm = 64'($signed({inst[31:12], 12'h000}));
      STORE:      d.imm = 64'($signed({inst[31:25], inst[11:7]}));
      BRANCH:     d.imm = 64'($signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}));
      JAL:        d.imm = 64'($signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}));
      default:    d.imm = '0;
    endcase
    case (classify(inst))
      0:  d.ctrl = pack_ctrl(4'b1000, 2'b01, ALU_COPY_IMM, MEM_NONE, BR_NONE, IMM_U);
      1:  d.ctrl = pack_ctrl(4'b1100, 2'b01, ALU_ADD, MEM_NONE, BR_NONE, IMM_U);
      2:  d.ctrl = pack_ctrl(4'b1100, 2'b10, ALU_ADD, MEM_NONE, BR_JAL, IMM_J);
      3:  d.ctrl = pack_ctrl(4'b1100, 2'b10, ALU_ADD, MEM_NONE, BR_JALR, IMM_I);
      4:  d.ctrl = pack_ctrl(4'b0000, 2'b00, ALU_SUB, MEM_NONE, BR_BNE, IMM_B);
      5:  d.ctrl = pack_ctrl(4'b1010, 2'b01, ALU_ADD, MEM_SW, BR_NONE, IMM_I);
      6:  d.ctrl = pack_ctrl(4'b0001, 2'b01, ALU_ADD, MEM_SW, BR_NONE, IMM_S);
      7:  d.ctrl = pack_ctrl(4'b1000, 2'b01, ALU_ADD, MEM_NONE, BR_NONE, IMM_I);
      8:  d.ctrl = pack_ctrl(4'b1000, 2'b01, ALU_EBREAK, MEM_NONE, BR_NONE, IMM_I);
      9:  d.ctrl = pack_ctrl(4'b0001, 2'b01, ALU_ADD, MEM_SD, BR_NONE, IMM_S);
      10: d.ctrl = pack_ctrl(4'b1000, 2'b01, ALU_ADDW, MEM_NONE, BR_NONE, IMM_I);
      11: d.ctrl = pack_ctrl(4'b1000, 2'b00, ALU_ADDW, MEM_NONE, BR_NONE, IMM_NONE);
      default: begin
        d.ctrl = pack_ctrl(4'b0000, 2'b00, ALU_NONE, MEM_NONE, BR_NONE, IMM_NONE);
        d.ctrl.illegal = 1'b1;
      end
    endcase
    return d;
  endfunction

  task automatic check_outputs();
    dec_pkt_t exp;
    if (inst_credit) begin
      fetch_credits++;
      if (fetch_credits > DEPTH) begin
        errors++;
        $display("%s: credit returned to fetch without a packet leaving", test_name);
      end
    end
    if (dec_valid) begin
      received++;
      if (received > ex_granted) begin
        errors++;
        $display("%s: packet sent without an execute credit", test_name);
      end
      if (exp_q.size() == 0) begin
        errors++;
        $display("%s: packet sent while none was expected", test_name);
      end else begin
        exp = exp_q.pop_front();
        if (dec !== exp) begin
          errors++;
          $display("ERROR %s: expected %h actual %h", test_name, exp, dec);
        end
      end
    end
  endtask

  // one clock: look at the outputs, then drive the next inputs on the falling edge
  task automatic cycle(input logic want_send, input logic give_credit);
    logic [31:0] inst;
    int          kind;
    @(negedge clk);
    check_outputs();
    inst_valid = 1'b0;
    if (want_send && fetch_credits > 0) begin
      if (rand_bits(3) == 0) inst = rand_bits(32); // garbage, mostly illegal
      else inst = make_inst(rand_bits(4) % 12, rand_bits(32));
      inst_pkt.pc[63:32] = rand_bits(32);
      inst_pkt.pc[31:0]  = rand_bits(30) << 2;
      inst_pkt.inst      = inst;
      inst_valid         = 1'b1;
      kind = classify(inst);
      if (kind >= 0) legal_seen[kind] = 1'b1;
      else illegal_sent++;
      exp_q.push_back(ref_decode(inst_pkt.pc, inst));
      fetch_credits--;
      sent++;
    end
    ex_credit = give_credit;
    if (give_credit) ex_granted++;
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    inst_valid = 1'b0;
    inst_pkt   = '0;
    ex_credit  = 1'b0;
    begin : run
      int t;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      repeat (5) cycle(1'b0, 1'b0);
      test_name = "no_ex_credit";
      for (t = 0; t < 50 && fetch_credits > 0; t++) cycle(1'b1, 1'b0);
      if (fetch_credits > 0) begin
        $display("timeout: fetch credits never ran out while execute was stalled");
        timeouts++;
        disable run;
      end
      repeat (10) cycle(1'b1, 1'b0); // buffer full and fetch starved, nothing moves
      if (sent != DEPTH || received != 0) begin
        errors++;
        $display("ERROR %s: expected %0d held, actual %0d sent %0d out", test_name,
                 DEPTH, sent, received);
      end
      test_name = "random_flow";
      for (t = 0; t < 20000 && sent < N_PKT; t++) cycle(rand_bits(2) != 0, rand_bits(1) != 0);
      if (sent < N_PKT) begin
        $display("timeout: only %0d packets accepted in the random phase", sent);
        timeouts++;
        disable run;
      end
      test_name = "drain";
      for (t = 0; t < 1000 && (exp_q.size() > 0 || fetch_credits != DEPTH); t++)
        cycle(1'b0, 1'b1);
      if (exp_q.size() > 0 || fetch_credits != DEPTH) begin
        $display("timeout: buffer did not drain or fetch credits were not all returned");
        timeouts++;
        disable run;
      end
      if (legal_seen != 12'hfff || illegal_sent == 0) begin
        errors++;
        $display("not every legal instruction and no illegal encoding was exercised");
      end
    end
    $display("errors %0d timeouts %0d sent %0d received %0d illegal %0d", errors, timeouts,
             sent, received, illegal_sent);
    if (errors == 0 && timeouts == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+include
rtl/idu_pkg.sv
rtl/idu_imm_gen.sv
rtl/idu_ctrl_dec.sv
rtl/idu_issue_buf.sv
rtl/idu_top.sv
sim/tb_idu.sv

//--- Bender.yml
package:
  name: idu

export_include_dirs:
  - include

sources:
  - rtl/idu_pkg.sv
  - rtl/idu_imm_gen.sv
  - rtl/idu_ctrl_dec.sv
  - rtl/idu_issue_buf.sv
  - rtl/idu_top.sv
  - target: test
    files:
      - sim/tb_idu.sv
